// ==== logic/cache_geom_pkg.sv ====
// cache geometry and address fields
package cache_geom_pkg;

	localparam int ADDR_W = 16;
	localparam int WORD_W = 16;
	localparam int OFFSET_W = 2;
	localparam int INDEX_W = 4;
	localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W - 1; // bit 0 is the byte bit
	localparam int NUM_LINES = 1 << INDEX_W;
	localparam int WORDS_PER_LINE = 1 << OFFSET_W;
	localparam int MEM_WORDS = 1 << (ADDR_W - 1); // one entry per aligned word

	typedef logic [ADDR_W-1:0]   addr_t;
	typedef logic [WORD_W-1:0]   word_t;
	typedef logic [TAG_W-1:0]    tag_t;
	typedef logic [INDEX_W-1:0]  index_t;
	typedef logic [OFFSET_W-1:0] offset_t;

	function automatic tag_t addr_tag(addr_t a);
		return a[ADDR_W-1 -: TAG_W];
	endfunction

	function automatic index_t addr_index(addr_t a);
		return a[OFFSET_W+1 +: INDEX_W];
	endfunction

	function automatic offset_t addr_offset(addr_t a);
		return a[1 +: OFFSET_W];
	endfunction

	function automatic addr_t make_addr(tag_t t, index_t i, offset_t o);
		return {t, i, o, 1'b0};
	endfunction

endpackage

// ==== logic/mem_bus_pkg.sv ====
// memory port and cache write types
package mem_bus_pkg;
	import cache_geom_pkg::*;

	localparam int MEM_LATENCY = 4; // cycles from read request to response

	typedef struct packed {
		logic  valid;
		logic  write; // 1 = store, 0 = line read
		addr_t addr;
		word_t wdata;
	} mem_req_t;

	typedef struct packed {
		logic  valid;
		word_t rdata;
	} mem_rsp_t;

	typedef struct packed {
		logic    data_we;
		logic    tag_we; // also sets the valid bit
		index_t  index;
		offset_t offset;
		tag_t    tag;
		word_t   wdata;
	} cache_write_t;

	typedef enum logic [1:0] {
		idle,
		i_fill,
		d_fill,
		store_wait
	} fill_state_t;

endpackage

// ==== logic/cache_array.sv ====
// direct-mapped cache storage
`timescale 1ns/1ps

module cache_array
	import cache_geom_pkg::*;
	import mem_bus_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,
	input  addr_t        lookup_addr,
	input  cache_write_t wr,
	output logic         hit,
	output word_t        rdata
);

	tag_t                 tag_mem [NUM_LINES];
	word_t                data_mem [NUM_LINES*WORDS_PER_LINE];
	logic [NUM_LINES-1:0] valid;

	tag_t    lk_tag;
	index_t  lk_index;
	offset_t lk_offset;

	assign lk_tag = addr_tag(lookup_addr);
	assign lk_index = addr_index(lookup_addr);
	assign lk_offset = addr_offset(lookup_addr);

	// one valid bit per line
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			valid <= '0;
		end
		else if (wr.tag_we)
		begin
			valid[wr.index] <= 1'b1; // line complete with its last word
		end
	end

	always_ff @(posedge clk)
	begin
		if (wr.tag_we)
		begin
			tag_mem[wr.index] <= wr.tag;
		end
		if (wr.data_we)
		begin
			data_mem[{wr.index, wr.offset}] <= wr.wdata;
		end
	end

	// lookup result comes in the address cycle
	assign hit = valid[lk_index] && (tag_mem[lk_index] == lk_tag);
	assign rdata = data_mem[{lk_index, lk_offset}];

endmodule

// ==== logic/fill_counter.sv ====
// line fill word counters
`timescale 1ns/1ps

module fill_counter
	import cache_geom_pkg::*;
(
	input  logic    clk,
	input  logic    rst_n,
	input  logic    start,
	input  logic    rsp_valid,
	output offset_t issue_offset,
	output offset_t recv_offset,
	output logic    issue_done,
	output logic    fill_done
);

	offset_t issue_cnt;
	offset_t recv_cnt;
	logic    issuing;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			issue_cnt <= '0;
			recv_cnt <= '0;
			issuing <= 1'b0;
		end
		else if (start)
		begin
			issue_cnt <= '0;
			recv_cnt <= '0;
			issuing <= 1'b1; // first request goes out next cycle
		end
		else
		begin
			if (issuing)
			begin
				issue_cnt <= issue_cnt + 1'b1;
				if (issue_cnt == offset_t'(WORDS_PER_LINE - 1))
				begin
					issuing <= 1'b0;
				end
			end
			if (rsp_valid)
			begin
				recv_cnt <= recv_cnt + 1'b1;
			end
		end
	end

	assign issue_offset = issue_cnt;
	assign recv_offset = recv_cnt;
	assign issue_done = !issuing;
	assign fill_done = rsp_valid && (recv_cnt == offset_t'(WORDS_PER_LINE - 1)); // last word back

endmodule

// ==== logic/fill_controller.sv ====
// miss and store controller
`timescale 1ns/1ps

module fill_controller
	import cache_geom_pkg::*;
	import mem_bus_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,
	input  addr_t        pc,
	input  addr_t        data_addr,
	input  word_t        data_wdata,
	input  logic         mem_read,
	input  logic         mem_write,
	input  logic         i_hit,
	input  logic         d_hit,
	output cache_write_t i_wr,
	output cache_write_t d_wr,
	output mem_req_t     req,
	input  word_t        rsp_rdata,
	input  logic         rsp_valid,
	output logic         fill_start,
	input  offset_t      issue_offset,
	input  offset_t      recv_offset,
	input  logic         issue_done,
	input  logic         fill_done,
	output logic         if_stall,
	output logic         mem_stall
);

	fill_state_t  state;
	fill_state_t  next_state;
	logic         i_miss;
	logic         d_miss;
	logic         fill_active;
	logic         idle_store;
	logic         store_now;
	addr_t        store_addr;
	word_t        store_wdata;
	tag_t         line_tag;
	index_t       line_index;
	logic         pend_valid;
	logic         pend_hit;
	addr_t        pend_addr;
	word_t        pend_wdata;
	cache_write_t fill_wr;
	cache_write_t store_wr;

	assign i_miss = !i_hit;
	assign d_miss = mem_read && !d_hit;
	assign fill_active = (state == i_fill) || (state == d_fill);
	assign idle_store = (state == idle) && mem_write && !d_miss;
	assign store_now = idle_store || (state == store_wait);

	always_comb
	begin
		next_state = state;
		case (state)
			idle:
			begin
				if (d_miss)
					next_state = d_fill; // data side has priority
				else if (i_miss)
					next_state = i_fill;
			end
			i_fill, d_fill:
			begin
				if (fill_done)
				begin
					if (pend_valid || mem_write)
						next_state = store_wait;
					else if (state == i_fill && d_miss)
						next_state = d_fill;
					else if (state == d_fill && i_miss)
						next_state = i_fill;
					else
						next_state = idle;
				end
			end
			default:
				next_state = idle; // store_wait lasts one cycle
		endcase
	end

	assign fill_start = (next_state != state) && (next_state == i_fill || next_state == d_fill);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= idle;
			pend_valid <= 1'b0;
		end
		else
		begin
			state <= next_state;
			if (state == store_wait)
				pend_valid <= 1'b0;
			else if (fill_active && mem_write)
				pend_valid <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (fill_start)
		begin
			line_tag <= addr_tag((next_state == d_fill) ? data_addr : pc);
			line_index <= addr_index((next_state == d_fill) ? data_addr : pc);
		end
		if (fill_active && mem_write && !pend_valid)
		begin
			pend_addr <= data_addr;
			pend_wdata <= data_wdata;
			pend_hit <= d_hit; // dcache does not change under an ifetch fill
		end
	end

	assign store_addr = (state == store_wait) ? pend_addr : data_addr;
	assign store_wdata = (state == store_wait) ? pend_wdata : data_wdata;

	always_comb
	begin
		req = '0;
		if (fill_active && !issue_done)
		begin
			req.valid = 1'b1;
			req.addr = make_addr(line_tag, line_index, issue_offset);
		end
		else if (store_now)
		begin
			req.valid = 1'b1; // write-through
			req.write = 1'b1;
			req.addr = store_addr;
			req.wdata = store_wdata;
		end
	end

	always_comb
	begin
		fill_wr.data_we = rsp_valid;
		fill_wr.tag_we = fill_done;
		fill_wr.index = line_index;
		fill_wr.offset = recv_offset;
		fill_wr.tag = line_tag;
		fill_wr.wdata = rsp_rdata;

		store_wr.data_we = (idle_store && d_hit) || (state == store_wait && pend_hit);
		store_wr.tag_we = 1'b0; // no allocate on a store miss
		store_wr.index = addr_index(store_addr);
		store_wr.offset = addr_offset(store_addr);
		store_wr.tag = addr_tag(store_addr);
		store_wr.wdata = store_wdata;
	end

	assign i_wr = (state == i_fill) ? fill_wr : '0;
	assign d_wr = (state == d_fill) ? fill_wr : store_wr;

	assign if_stall = i_miss || (state == i_fill);
	assign mem_stall = d_miss || (fill_active && mem_write);

endmodule

// ==== logic/backing_memory.sv ====
// fixed-latency backing memory model
`timescale 1ns/1ps

module backing_memory
	import cache_geom_pkg::*;
	import mem_bus_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  mem_req_t req,
	output mem_rsp_t rsp
);

	word_t                  mem [MEM_WORDS];
	logic [MEM_LATENCY-1:0] pipe_valid;
	word_t                  pipe_data [MEM_LATENCY];

	initial
	begin
		for (int i = 0; i < MEM_WORDS; i++)
		begin
			mem[i] = '0;
		end
	end

	// writes land on the edge and give no response
	always @(posedge clk)
	begin
		if (req.valid && req.write)
		begin
			mem[req.addr[ADDR_W-1:1]] <= req.wdata;
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pipe_valid <= '0;
		end
		else
		begin
			pipe_valid <= {pipe_valid[MEM_LATENCY-2:0], req.valid && !req.write};
		end
	end

	// read data moves alongside its valid bit
	always_ff @(posedge clk)
	begin
		pipe_data[0] <= mem[req.addr[ADDR_W-1:1]];
		for (int i = 1; i < MEM_LATENCY; i++)
		begin
			pipe_data[i] <= pipe_data[i-1];
		end
	end

	assign rsp.valid = pipe_valid[MEM_LATENCY-1];
	assign rsp.rdata = pipe_data[MEM_LATENCY-1];

endmodule

// ==== logic/mem_hier_top.sv ====
// instruction and data cache hierarchy
`timescale 1ns/1ps

module mem_hier_top
	import cache_geom_pkg::*;
	import mem_bus_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	input  addr_t pc,
	output word_t instr,
	output logic  if_stall,
	input  addr_t data_addr,
	input  word_t data_wdata,
	input  logic  mem_read,
	input  logic  mem_write,
	output word_t data_rdata,
	output logic  mem_stall
);

	logic         i_hit;
	logic         d_hit;
	cache_write_t i_wr;
	cache_write_t d_wr;
	mem_req_t     req;
	mem_rsp_t     rsp;
	logic         fill_start;
	offset_t      issue_offset;
	offset_t      recv_offset;
	logic         issue_done;
	logic         fill_done;

	cache_array i_icache (.clk(clk), .rst_n(rst_n), .lookup_addr(pc), .wr(i_wr),
		.hit(i_hit), .rdata(instr));

	cache_array i_dcache (.clk(clk), .rst_n(rst_n), .lookup_addr(data_addr), .wr(d_wr),
		.hit(d_hit), .rdata(data_rdata));

	fill_controller i_fill_ctrl (.clk(clk), .rst_n(rst_n), .pc(pc), .data_addr(data_addr),
		.data_wdata(data_wdata), .mem_read(mem_read), .mem_write(mem_write),
		.i_hit(i_hit), .d_hit(d_hit), .i_wr(i_wr), .d_wr(d_wr), .req(req),
		.rsp_rdata(rsp.rdata), .rsp_valid(rsp.valid), .fill_start(fill_start),
		.issue_offset(issue_offset), .recv_offset(recv_offset), .issue_done(issue_done),
		.fill_done(fill_done), .if_stall(if_stall), .mem_stall(mem_stall));

	fill_counter i_fill_cnt (.clk(clk), .rst_n(rst_n), .start(fill_start),
		.rsp_valid(rsp.valid), .issue_offset(issue_offset), .recv_offset(recv_offset),
		.issue_done(issue_done), .fill_done(fill_done));

	backing_memory i_mem (.clk(clk), .rst_n(rst_n), .req(req), .rsp(rsp));

endmodule

// ==== testbench/mem_hier_tb.sv ====
// memory hierarchy testbench
`timescale 1ns/1ps

module mem_hier_tb
	import cache_geom_pkg::*;
	import mem_bus_pkg::*;
();

	typedef enum logic [2:0] {
		k_fetch,
		k_read,
		k_write,
		k_fetch_read,  // both sides miss in the same cycle
		k_fetch_write  // store arrives one cycle into the instruction fill
	} kind_e;

	typedef struct packed {
		kind_e kind;
		logic  exp_stall; // the access must see its stall(s) raised
		addr_t addr;
		word_t wdata;
		word_t exp;
	} row_t;

	localparam int NUM_ROWS = 18;
	localparam int WATCHDOG_CYCLES = NUM_ROWS * 2 * (MEM_LATENCY + 8) + 20;

	logic  clk;
	logic  rst_n;
	addr_t pc;
	word_t instr;
	logic  if_stall;
	addr_t data_addr;
	word_t data_wdata;
	logic  mem_read;
	logic  mem_write;
	word_t data_rdata;
	logic  mem_stall;

	row_t   rows [NUM_ROWS];
	string  row_names [NUM_ROWS];
	word_t  ref_words [MEM_WORDS]; // contents the backing memory should hold
	int     n_rows;
	int     errors;
	int     checks;
	integer seed;

	mem_hier_top i_dut (.clk(clk), .rst_n(rst_n), .pc(pc), .instr(instr), .if_stall(if_stall),
		.data_addr(data_addr), .data_wdata(data_wdata), .mem_read(mem_read),
		.mem_write(mem_write), .data_rdata(data_rdata), .mem_stall(mem_stall));

	always #10 clk = ~clk;

	task automatic add_row(input string name, input kind_e kind, input addr_t addr,
		input logic exp_stall);
		row_t row;
		row.kind = kind;
		row.exp_stall = exp_stall;
		row.addr = addr;
		row.wdata = '0;
		if (kind == k_write || kind == k_fetch_write)
			row.wdata = word_t'($random(seed));
		row.exp = ref_words[addr[ADDR_W-1:1]]; // value before this row's own store
		if (kind == k_write || kind == k_fetch_write)
			ref_words[addr[ADDR_W-1:1]] = row.wdata; // write-through reaches memory
		rows[n_rows] = row;
		row_names[n_rows] = name;
		n_rows++;
	endtask

	// tag = addr[15:7], index = addr[6:3], word = addr[2:1]
	task automatic build_table();
		n_rows = 0;
		add_row("cold_read",            k_read,        16'h0100, 1'b1);
		add_row("cold_write",           k_write,       16'h0210, 1'b0);
		add_row("read_after_miss_write", k_read,       16'h0210, 1'b1);
		add_row("read_hit_same_word",   k_read,        16'h0210, 1'b0);
		add_row("read_hit_other_word",  k_read,        16'h0212, 1'b0);
		add_row("write_hit",            k_write,       16'h0102, 1'b0);
		add_row("read_after_write_hit", k_read,        16'h0102, 1'b0);
		add_row("fetch_after_write_hit", k_fetch,      16'h0102, 1'b1);
		add_row("conflict_write_a",     k_write,       16'h0428, 1'b0); // index 5, tag 8
		add_row("conflict_write_b",     k_write,       16'h0ca8, 1'b0); // index 5, tag 25
		add_row("conflict_read_a",      k_read,        16'h0428, 1'b1);
		add_row("conflict_read_b",      k_read,        16'h0ca8, 1'b1);
		add_row("conflict_reread_a",    k_read,        16'h0428, 1'b1);
		add_row("conflict_reread_b",    k_read,        16'h0ca8, 1'b1);
		add_row("arb_setup_write",      k_write,       16'h1234, 1'b0);
		add_row("arb_fetch_and_read",   k_fetch_read,  16'h1234, 1'b1);
		add_row("store_during_ifill",   k_fetch_write, 16'h2348, 1'b1);
		add_row("read_after_held_store", k_read,       16'h2348, 1'b1);
	endtask

	task automatic check_value(input string name, input string what, input word_t exp,
		input word_t act);
		checks++;
		assert (act === exp)
		else
		begin
			$display("MISMATCH %s %s: expected %h, actual %h", name, what, exp, act);
			errors++;
		end
	endtask

	task automatic check_stall(input string name, input string side, input logic exp,
		input logic saw);
		checks++;
		assert (saw == exp)
		else
		begin
			if (exp)
				$display("%s: %s stall was expected but never raised", name, side);
			else
				$display("%s: %s stall was raised on an access that should hit", name, side);
			errors++;
		end
	endtask

	task automatic run_row(input int r);
		row_t  row;
		logic  use_i;
		logic  use_d;
		logic  i_done;
		logic  d_done;
		logic  saw_i;
		logic  saw_d;
		int    cycle;
		int    i_cycle;
		int    d_cycle;
		int    err_before;
		word_t act_i;
		word_t act_d;
		row = rows[r];
		use_i = (row.kind == k_fetch) || (row.kind == k_fetch_read) || (row.kind == k_fetch_write);
		use_d = (row.kind != k_fetch);
		saw_i = 1'b0;
		saw_d = 1'b0;
		act_i = '0;
		act_d = '0;
		i_cycle = 0;
		d_cycle = 0;
		err_before = errors;

		@(posedge clk);
		if (use_i)
			pc <= row.addr;
		if (row.kind != k_fetch && row.kind != k_fetch_write)
			data_addr <= row.addr;
		data_wdata <= row.wdata;
		mem_read <= (row.kind == k_read) || (row.kind == k_fetch_read);
		mem_write <= (row.kind == k_write);

		if (row.kind == k_fetch_write)
		begin
			@(negedge clk);
			saw_i = if_stall;
			@(posedge clk); // instruction fill is now running
			data_addr <= row.addr;
			mem_write <= 1'b1;
		end

		i_done = !use_i;
		d_done = !use_d;
		cycle = 0;
		while (!(i_done && d_done))
		begin
			@(negedge clk); // outputs settled mid-cycle
			if (!i_done)
			begin
				if (if_stall)
					saw_i = 1'b1;
				else
				begin
					i_done = 1'b1;
					i_cycle = cycle;
					act_i = instr;
				end
			end
			if (!d_done)
			begin
				if (mem_stall)
					saw_d = 1'b1;
				else
				begin
					d_done = 1'b1;
					d_cycle = cycle;
					act_d = data_rdata;
				end
			end
			cycle++;
		end

		if (use_i)
		begin
			check_stall(row_names[r], "fetch", row.exp_stall, saw_i);
			check_value(row_names[r], "instr", row.exp, act_i);
		end
		if (use_d)
			check_stall(row_names[r], "data", row.exp_stall, saw_d);
		if (row.kind == k_read || row.kind == k_fetch_read)
			check_value(row_names[r], "data_rdata", row.exp, act_d);
		if (row.kind == k_fetch_read)
		begin
			checks++;
			assert (d_cycle <= i_cycle)
			else
			begin
				$display("%s: data miss released after the fetch miss", row_names[r]);
				errors++;
			end
		end
		$display("row %0d %s %s after %0d cycles", r, row_names[r],
			(errors == err_before) ? "ok" : "FAIL", cycle);
	endtask

	initial
	begin
		clk = 1'b0;
		rst_n = 1'b0;
		pc = '0;
		data_addr = '0;
		data_wdata = '0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		errors = 0;
		checks = 0;
		seed = 32'hde15;
		for (int i = 0; i < MEM_WORDS; i++)
			ref_words[i] = '0;
		build_table();

		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		while (if_stall) // icache fills the line of the reset pc first
			@(negedge clk);

		for (int r = 0; r < n_rows; r++)
			run_row(r);
		@(posedge clk);
		mem_read <= 1'b0;
		mem_write <= 1'b0;

		$display("%0d rows, %0d checks, %0d errors", n_rows, checks, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	// run limit allows two fills per row
	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("TIMEOUT: a stall did not release within %0d cycles", WATCHDOG_CYCLES);
		$display("Regression failed");
		$finish;
	end

endmodule

// ==== sim.f ====
logic/cache_geom_pkg.sv
logic/mem_bus_pkg.sv
logic/cache_array.sv
logic/fill_counter.sv
logic/fill_controller.sv
logic/backing_memory.sv
logic/mem_hier_top.sv
testbench/mem_hier_tb.sv

// ==== Bender.yml ====
package:
  name: mem_hier

sources:
  - files:
      - logic/cache_geom_pkg.sv
      - logic/mem_bus_pkg.sv
      - logic/cache_array.sv
      - logic/fill_counter.sv
      - logic/fill_controller.sv
      - logic/backing_memory.sv
      - logic/mem_hier_top.sv
  - target: simulation
    files:
      - testbench/mem_hier_tb.sv
